/* mfp_defines.svh */
// mfp constants: fifo pointer width, timer prescaler divisors, interrupt source numbers
`ifndef MFP_DEFINES_SVH
`define MFP_DEFINES_SVH

// fifo pointer width, 16 entries per direction
`define MFP_FIFO_ADDR_BITS 4

// clk_ext divisors for timer delay modes 1 to 7
`define MFP_PRESCALE_1 8'd4
`define MFP_PRESCALE_2 8'd10
`define MFP_PRESCALE_3 8'd16
`define MFP_PRESCALE_4 8'd50
`define MFP_PRESCALE_5 8'd64
`define MFP_PRESCALE_6 8'd100
`define MFP_PRESCALE_7 8'd200

// bit positions in the 16-bit interrupt registers
// timers
`define MFP_IRQ_TIMER_A 13
`define MFP_IRQ_TIMER_B 8
`define MFP_IRQ_TIMER_C 5
`define MFP_IRQ_TIMER_D 4

// serial channel
`define MFP_IRQ_TX_EMPTY 10
`define MFP_IRQ_RX_FULL 12

// port inputs, falling edge after aer polarity
`define MFP_IRQ_GPIP3 3
`define MFP_IRQ_GPIP4 6
`define MFP_IRQ_GPIP5 7
`define MFP_IRQ_GPIP7 15

`endif

/* mfp_pkg.sv */
// mfp types: register address enum, timer mode enum, write structs
package mfp_pkg;

	// cpu register window, 5-bit address
	typedef enum logic [4:0] {
		REG_GPIP  = 5'h00,
		REG_AER   = 5'h01,
		REG_DDR   = 5'h02,
		REG_IERA  = 5'h03,
		REG_IERB  = 5'h04,
		REG_IPRA  = 5'h05,
		REG_IPRB  = 5'h06,
		REG_ISRA  = 5'h07,
		REG_ISRB  = 5'h08,
		REG_IMRA  = 5'h09,
		REG_IMRB  = 5'h0A,
		REG_VR    = 5'h0B,
		REG_TACR  = 5'h0C,
		REG_TBCR  = 5'h0D,
		REG_TCDCR = 5'h0E,
		REG_TADR  = 5'h0F,
		REG_TBDR  = 5'h10,
		REG_TCDR  = 5'h11,
		REG_TDDR  = 5'h12,
		REG_SCR   = 5'h13,
		REG_UCR   = 5'h14,
		REG_RSR   = 5'h15,
		REG_TSR   = 5'h16,
		REG_UDR   = 5'h17
	} mfp_reg_e;

	// timer control field
	typedef enum logic [3:0] {
		TM_STOP      = 4'd0,
		TM_DELAY_4   = 4'd1,
		TM_DELAY_10  = 4'd2,
		TM_DELAY_16  = 4'd3,
		TM_DELAY_50  = 4'd4,
		TM_DELAY_64  = 4'd5,
		TM_DELAY_100 = 4'd6,
		TM_DELAY_200 = 4'd7,
		TM_EVENT     = 4'd8
	} timer_mode_e;

	// one cpu write, valid for a single clock
	typedef struct packed {
		logic       strobe;
		mfp_reg_e   addr;
		logic [7:0] data;
	} reg_wr_t;

	// decoded write to one timer
	typedef struct packed {
		logic       ctrl_we;
		logic [3:0] ctrl;
		logic       data_we;
		logic [7:0] data;
	} timer_wr_t;

endpackage

/* mfp_timer.sv */
// mfp timer: clk_ext prescaler, 8-bit down counter, event input, reload and expiry pulse
`include "mfp_defines.svh"

module mfp_timer #(
	parameter int HAS_EVENT = 1
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 xclk_i,
	input  mfp_pkg::timer_wr_t   wr_i,
	input  logic                 event_i,
	output mfp_pkg::timer_mode_e ctrl_o,
	output logic [7:0]           data_o,
	output logic                 done_o
);
	import mfp_pkg::*;

	timer_mode_e mode;
	timer_mode_e new_mode;
	logic [7:0] reload;
	logic [7:0] count;
	logic [7:0] prescale_cnt;
	logic [7:0] divisor;
	logic xclk_d;
	logic event_d;
	logic xclk_rise;
	logic event_fall;
	logic is_delay;
	logic step;

	// xclk_i already comes through the top level synchronizer
	assign xclk_rise = xclk_i & ~xclk_d;
	assign event_fall = ~event_i & event_d;
	assign is_delay = (mode != TM_STOP) && (mode != TM_EVENT);

	always_comb begin
		case (mode)
			TM_DELAY_4:   divisor = `MFP_PRESCALE_1;
			TM_DELAY_10:  divisor = `MFP_PRESCALE_2;
			TM_DELAY_16:  divisor = `MFP_PRESCALE_3;
			TM_DELAY_50:  divisor = `MFP_PRESCALE_4;
			TM_DELAY_64:  divisor = `MFP_PRESCALE_5;
			TM_DELAY_100: divisor = `MFP_PRESCALE_6;
			TM_DELAY_200: divisor = `MFP_PRESCALE_7;
			default:      divisor = 8'd1;
		endcase
	end

	// timers without event input ignore control bit 3
	always_comb begin
		if (HAS_EVENT != 0 && wr_i.ctrl[3])
			new_mode = TM_EVENT;
		else
			new_mode = timer_mode_e'({1'b0, wr_i.ctrl[2:0]});
	end

	always_comb begin
		if (is_delay)
			step = xclk_rise && (prescale_cnt == divisor - 8'd1);
		else
			step = (HAS_EVENT != 0) && (mode == TM_EVENT) && event_fall;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= TM_STOP;
			count <= 8'd0;
			prescale_cnt <= 8'd0;
			done_o <= 1'b0;
			xclk_d <= 1'b0;
			event_d <= 1'b0;
		end else begin
			xclk_d <= xclk_i;
			event_d <= event_i;
			done_o <= 1'b0;
			if (wr_i.ctrl_we) begin
				mode <= new_mode;
				prescale_cnt <= 8'd0;
			end else if (is_delay && xclk_rise) begin
				prescale_cnt <= step ? 8'd0 : prescale_cnt + 8'd1;
			end
			// a stopped timer loads the counter directly
			if (wr_i.data_we && mode == TM_STOP) begin
				count <= wr_i.data;
			end else if (step) begin
				if (count == 8'd1) begin
					count <= reload;
					done_o <= 1'b1;
				end else begin
					count <= count - 8'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_i.data_we)
			reload <= wr_i.data;
	end

	assign ctrl_o = mode;
	assign data_o = count;

endmodule

/* mfp_byte_fifo.sv */
// mfp byte fifo: 16-entry circular buffer with empty and full flags
`include "mfp_defines.svh"

module mfp_byte_fifo (
	input  logic       clk,
	input  logic       reset,
	input  logic       push_i,
	input  logic [7:0] data_i,
	input  logic       pop_i,
	output logic [7:0] data_o,
	output logic       empty_o,
	output logic       full_o
);
	localparam int ADDR_BITS = `MFP_FIFO_ADDR_BITS;
	localparam int DEPTH = 1 << ADDR_BITS;

	logic [7:0] mem [DEPTH];
	logic [ADDR_BITS-1:0] wr_ptr;
	logic [ADDR_BITS-1:0] rd_ptr;
	logic [ADDR_BITS-1:0] wr_next;

	assign wr_next = wr_ptr + 1'b1;
	assign empty_o = (wr_ptr == rd_ptr);
	// one slot stays free, so full means 15 entries
	assign full_o = (wr_next == rd_ptr);
	assign data_o = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push_i && !full_o)
				wr_ptr <= wr_next;
			if (pop_i && !empty_o)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push_i && !full_o)
			mem[wr_ptr] <= data_i;
	end

endmodule

/* mfp_irq_ctrl.sv */
// mfp interrupt controller: ier, ipr, imr, isr and vr, priority encoders, acknowledge, vector latch
module mfp_irq_ctrl (
	input  logic              clk,
	input  logic              reset,
	input  mfp_pkg::reg_wr_t  wr_i,
	input  mfp_pkg::mfp_reg_e rd_addr_i,
	input  logic [15:0]       irq_src_i,
	input  logic              iack_i,
	output logic              irq_o,
	output logic [7:0]        vector_o,
	output logic [7:0]        rd_data_o
);
	import mfp_pkg::*;

	logic [15:0] ier;
	logic [15:0] ipr;
	logic [15:0] imr;
	logic [15:0] isr;
	logic [7:0] vr;
	logic [15:0] pend_map;
	logic [15:0] ipr_clr;
	logic [15:0] isr_set;
	logic [15:0] isr_clr;
	logic [15:0] ack_mask;
	logic [3:0] pend_num;
	logic [3:0] isr_num;
	logic iack_d;
	logic ack;

	// number of the highest set bit, 0 when none is set
	function automatic logic [3:0] highest_bit(input logic [15:0] vec);
		logic [3:0] num;
		num = 4'd0;
		for (int b = 0; b < 16; b++) begin
			if (vec[b])
				num = 4'(b);
		end
		return num;
	endfunction

	assign pend_map = ipr & imr;
	assign pend_num = highest_bit(pend_map);
	assign isr_num = highest_bit(isr);

	// an empty isr encodes as 0, which any pending bit passes
	assign irq_o = (pend_map != 16'h0000) && (pend_num >= isr_num);

	assign ack = iack_i && !iack_d && (pend_map != 16'h0000);
	assign ack_mask = 16'h0001 << pend_num;
	assign isr_set = (ack && vr[3]) ? ack_mask : 16'h0000;

	always_comb begin
		ipr_clr = ack ? ack_mask : 16'h0000;
		isr_clr = 16'h0000;
		if (wr_i.strobe) begin
			case (wr_i.addr)
				REG_IERA, REG_IPRA: ipr_clr[15:8] = ipr_clr[15:8] | ~wr_i.data;
				REG_IERB, REG_IPRB: ipr_clr[7:0] = ipr_clr[7:0] | ~wr_i.data;
				REG_ISRA:           isr_clr[15:8] = ~wr_i.data;
				REG_ISRB:           isr_clr[7:0] = ~wr_i.data;
				default:            ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ier <= 16'h0000;
			ipr <= 16'h0000;
			imr <= 16'h0000;
			isr <= 16'h0000;
			vr <= 8'h00;
			iack_d <= 1'b0;
		end else begin
			iack_d <= iack_i;
			ipr <= (ipr | (irq_src_i & ier)) & ~ipr_clr;
			isr <= (isr | isr_set) & ~isr_clr;
			if (wr_i.strobe) begin
				case (wr_i.addr)
					REG_IERA: ier[15:8] <= wr_i.data;
					REG_IERB: ier[7:0] <= wr_i.data;
					REG_IMRA: imr[15:8] <= wr_i.data;
					REG_IMRB: imr[7:0] <= wr_i.data;
					REG_VR:   vr <= wr_i.data;
					default:  ;
				endcase
			end
		end
	end

	// vector stays frozen for the whole acknowledge cycle
	always_ff @(posedge clk) begin
		if (!iack_i)
			vector_o <= {vr[7:4], pend_num};
	end

	always_comb begin
		case (rd_addr_i)
			REG_IERA: rd_data_o = ier[15:8];
			REG_IERB: rd_data_o = ier[7:0];
			REG_IPRA: rd_data_o = ipr[15:8];
			REG_IPRB: rd_data_o = ipr[7:0];
			REG_ISRA: rd_data_o = isr[15:8];
			REG_ISRB: rd_data_o = isr[7:0];
			REG_IMRA: rd_data_o = imr[15:8];
			REG_IMRB: rd_data_o = imr[7:0];
			REG_VR:   rd_data_o = vr;
			default:  rd_data_o = 8'h00;
		endcase
	end

endmodule

/* mfp.sv */
// mfp top level: access decode, gpip registers, synchronizers, edge detect, timers, fifos, read mux
`include "mfp_defines.svh"

module mfp (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] din_i,
	input  logic       sel_i,
	input  logic [4:0] addr_i,
	input  logic       ds_i,
	input  logic       rw_i,
	output logic [7:0] dout_o,
	output logic       irq_o,
	input  logic       iack_i,
	output logic       serial_avail_o,
	input  logic       serial_strobe_out_i,
	output logic [7:0] serial_data_o,
	input  logic       serial_strobe_in_i,
	input  logic [7:0] serial_data_i,
	input  logic       clk_ext_i,
	input  logic [1:0] t_i,
	input  logic [7:0] gpio_i
);
	import mfp_pkg::*;

	localparam int SYNC_W = 13;

	reg_wr_t reg_wr;
	mfp_reg_e rd_addr;
	timer_wr_t tmr_wr [4];
	timer_mode_e tmr_ctrl [4];
	logic [7:0] tmr_data [4];
	logic [3:0] tmr_done;
	logic [3:0] tmr_event;
	logic [SYNC_W-1:0] sync_1;
	logic [SYNC_W-1:0] sync_2;
	logic [7:0] gpio_sync;
	logic [1:0] t_sync;
	logic clk_ext_sync;
	logic strobe_in_sync;
	logic strobe_out_sync;
	logic strobe_in_d;
	logic strobe_out_d;
	logic [7:0] port_x;
	logic [7:0] port_d;
	logic [7:0] port_fall;
	logic [7:0] gpip;
	logic [7:0] aer;
	logic [7:0] ddr;
	logic [7:0] gpip_rd;
	logic [3:0] rx_ctrl;
	logic [3:0] tx_ctrl;
	logic wr_access;
	logic wr_access_d;
	logic rd_access;
	logic rd_udr;
	logic rd_udr_d;
	logic tx_empty;
	logic tx_full;
	logic rx_empty;
	logic rx_full;
	logic [7:0] rx_data;
	logic [1:0] ser_flags_d;
	logic [15:0] irq_src;
	logic [7:0] irq_rd_data;
	logic [7:0] irq_vector;

	assign wr_access = sel_i & ~ds_i & ~rw_i;
	assign rd_access = sel_i & ~ds_i & rw_i;
	assign rd_addr = mfp_reg_e'(addr_i);
	assign rd_udr = rd_access && (rd_addr == REG_UDR);

	// two-stage synchronizer for every asynchronous input
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_1 <= '0;
			sync_2 <= '0;
		end else begin
			sync_1 <= {gpio_i, t_i, clk_ext_i, serial_strobe_in_i, serial_strobe_out_i};
			sync_2 <= sync_1;
		end
	end

	assign {gpio_sync, t_sync, clk_ext_sync, strobe_in_sync, strobe_out_sync} = sync_2;

	// aer bit set turns a rising pin edge into a falling one
	assign port_x = gpio_sync ^ aer;
	assign port_fall = port_d & ~port_x;

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_wr.strobe <= 1'b0;
			wr_access_d <= 1'b0;
			rd_udr_d <= 1'b0;
			port_d <= 8'h00;
			strobe_in_d <= 1'b0;
			strobe_out_d <= 1'b0;
			ser_flags_d <= 2'b00;
		end else begin
			// a held access writes only once
			reg_wr.strobe <= wr_access & ~wr_access_d;
			reg_wr.addr <= mfp_reg_e'(addr_i);
			reg_wr.data <= din_i;
			wr_access_d <= wr_access;
			rd_udr_d <= rd_udr;
			port_d <= port_x;
			strobe_in_d <= strobe_in_sync;
			strobe_out_d <= strobe_out_sync;
			ser_flags_d <= {~tx_full, ~rx_empty};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			gpip <= 8'h00;
			aer <= 8'h00;
			ddr <= 8'h00;
			rx_ctrl <= 4'h0;
			tx_ctrl <= 4'h0;
		end else if (reg_wr.strobe) begin
			case (reg_wr.addr)
				REG_GPIP: gpip <= reg_wr.data;
				REG_AER:  aer <= reg_wr.data;
				REG_DDR:  ddr <= reg_wr.data;
				REG_RSR:  rx_ctrl <= reg_wr.data[3:0];
				REG_TSR:  tx_ctrl <= reg_wr.data[3:0];
				default:  ;
			endcase
		end
	end

	// C and D share one control register, C in the upper half
	always_comb begin
		tmr_wr[0] = '{reg_wr.strobe && reg_wr.addr == REG_TACR, reg_wr.data[3:0],
			reg_wr.strobe && reg_wr.addr == REG_TADR, reg_wr.data};
		tmr_wr[1] = '{reg_wr.strobe && reg_wr.addr == REG_TBCR, reg_wr.data[3:0],
			reg_wr.strobe && reg_wr.addr == REG_TBDR, reg_wr.data};
		tmr_wr[2] = '{reg_wr.strobe && reg_wr.addr == REG_TCDCR, {1'b0, reg_wr.data[6:4]},
			reg_wr.strobe && reg_wr.addr == REG_TCDR, reg_wr.data};
		tmr_wr[3] = '{reg_wr.strobe && reg_wr.addr == REG_TCDCR, {1'b0, reg_wr.data[2:0]},
			reg_wr.strobe && reg_wr.addr == REG_TDDR, reg_wr.data};
	end

	// only A and B count events, taking aer polarity bits 4 and 3
	assign tmr_event = {2'b00, t_sync[1] ^ aer[3], t_sync[0] ^ aer[4]};

	for (genvar i = 0; i < 4; i++) begin : g_timer
		mfp_timer #(
			.HAS_EVENT(i < 2)
		) u_timer (
			.clk(clk),
			.reset(reset),
			.xclk_i(clk_ext_sync),
			.wr_i(tmr_wr[i]),
			.event_i(tmr_event[i]),
			.ctrl_o(tmr_ctrl[i]),
			.data_o(tmr_data[i]),
			.done_o(tmr_done[i])
		);
	end

	mfp_byte_fifo u_tx_fifo (
		.clk(clk),
		.reset(reset),
		.push_i(reg_wr.strobe && reg_wr.addr == REG_UDR),
		.data_i(reg_wr.data),
		.pop_i(strobe_out_sync & ~strobe_out_d),
		.data_o(serial_data_o),
		.empty_o(tx_empty),
		.full_o(tx_full)
	);

	// cpu pops the receive head one clock after its read ends
	mfp_byte_fifo u_rx_fifo (
		.clk(clk),
		.reset(reset),
		.push_i(strobe_in_sync & ~strobe_in_d),
		.data_i(serial_data_i),
		.pop_i(rd_udr_d & ~rd_udr),
		.data_o(rx_data),
		.empty_o(rx_empty),
		.full_o(rx_full)
	);

	assign serial_avail_o = ~tx_empty;

	always_comb begin
		irq_src = 16'h0000;
		irq_src[`MFP_IRQ_TIMER_A] = tmr_done[0];
		irq_src[`MFP_IRQ_TIMER_B] = tmr_done[1];
		irq_src[`MFP_IRQ_TIMER_C] = tmr_done[2];
		irq_src[`MFP_IRQ_TIMER_D] = tmr_done[3];
		irq_src[`MFP_IRQ_GPIP3] = port_fall[3];
		irq_src[`MFP_IRQ_GPIP4] = port_fall[4];
		irq_src[`MFP_IRQ_GPIP5] = port_fall[5];
		irq_src[`MFP_IRQ_GPIP7] = port_fall[7];
		// transmit side has room again, receive side has data
		irq_src[`MFP_IRQ_TX_EMPTY] = ~tx_full & ~ser_flags_d[1];
		irq_src[`MFP_IRQ_RX_FULL] = ~rx_empty & ~ser_flags_d[0];
	end

	mfp_irq_ctrl u_irq (
		.clk(clk),
		.reset(reset),
		.wr_i(reg_wr),
		.rd_addr_i(rd_addr),
		.irq_src_i(irq_src),
		.iack_i(iack_i),
		.irq_o(irq_o),
		.vector_o(irq_vector),
		.rd_data_o(irq_rd_data)
	);

	// output pins read back the register, input pins the pin itself
	assign gpip_rd = (gpio_i & ~ddr) | (gpip & ddr);

	always_comb begin
		dout_o = 8'h00;
		if (rd_access) begin
			case (rd_addr)
				REG_GPIP:  dout_o = gpip_rd;
				REG_AER:   dout_o = aer;
				REG_DDR:   dout_o = ddr;
				REG_IERA, REG_IERB, REG_IPRA, REG_IPRB, REG_ISRA,
				REG_ISRB, REG_IMRA, REG_IMRB, REG_VR:
					dout_o = irq_rd_data;
				REG_TACR:  dout_o = {4'h0, tmr_ctrl[0]};
				REG_TBCR:  dout_o = {4'h0, tmr_ctrl[1]};
				REG_TCDCR: dout_o = {1'b0, tmr_ctrl[2][2:0], 1'b0, tmr_ctrl[3][2:0]};
				REG_TADR:  dout_o = tmr_data[0];
				REG_TBDR:  dout_o = tmr_data[1];
				REG_TCDR:  dout_o = tmr_data[2];
				REG_TDDR:  dout_o = tmr_data[3];
				REG_RSR:   dout_o = {~rx_empty, rx_full, 2'b00, rx_ctrl};
				REG_TSR:   dout_o = {~tx_full, 3'b000, tx_ctrl};
				REG_UDR:   dout_o = rx_data;
				default:   dout_o = 8'h00;
			endcase
		end else if (iack_i) begin
			dout_o = irq_vector;
		end
	end

endmodule

/* mfp_assert.sv */
// mfp checker: masked interrupts, serial idle after reset, idle read bus
module mfp_assert (
	input logic        clk,
	input logic        reset,
	input logic [15:0] imr_i,
	input logic        irq_i,
	input logic        avail_i,
	input logic [7:0]  dout_i,
	input logic        sel_i,
	input logic        ds_i,
	input logic        rw_i,
	input logic        iack_i
);
	timeunit 1ns;
	timeprecision 1ps;
	import mfp_pkg::*;

	int unsigned fail_count = 0;

	// a fully masked controller never requests
	irq_masked: assert property (@(posedge clk) disable iff (reset)
		(imr_i == 16'h0000) |-> !irq_i)
		else begin
			$error("irq_o high while imr is clear");
			fail_count++;
		end

	avail_after_reset: assert property (@(posedge clk) reset |=> !avail_i)
		else begin
			$error("serial_avail_o high right after reset");
			fail_count++;
		end

	// no read cycle and no acknowledge leaves the bus at zero
	bus_idle: assert property (@(posedge clk) disable iff (reset)
		(!(sel_i && !ds_i && rw_i) && !iack_i) |-> (dout_i == 8'h00))
		else begin
			$error("dout_o nonzero with no read and no acknowledge");
			fail_count++;
		end

endmodule

bind mfp mfp_assert u_mfp_assert (
	.clk(clk),
	.reset(reset),
	.imr_i(u_irq.imr),
	.irq_i(irq_o),
	.avail_i(serial_avail_o),
	.dout_i(dout_o),
	.sel_i(sel_i),
	.ds_i(ds_i),
	.rw_i(rw_i),
	.iack_i(iack_i)
);

/* tb_mfp.sv */
// testbench for mfp with clock, reset, cpu access tasks and a step table with checks
`include "mfp_defines.svh"

module tb_mfp;
	timeunit 1ns;
	timeprecision 1ps;
	import mfp_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int IRQ_TIMEOUT = 1000;
	localparam int AVAIL_TIMEOUT = 100;
	localparam logic [7:0] VR_VAL = 8'h48;
	localparam logic [15:0] M_G3 = 16'h0001 << `MFP_IRQ_GPIP3;
	localparam logic [15:0] M_G5 = 16'h0001 << `MFP_IRQ_GPIP5;
	localparam logic [15:0] M_TA = 16'h0001 << `MFP_IRQ_TIMER_A;
	localparam logic [15:0] M_TD = 16'h0001 << `MFP_IRQ_TIMER_D;

	typedef enum int {K_WR, K_RD, K_PIN, K_IRQ, K_NOIRQ, K_IACK, K_EVT, K_SIN, K_SOUT,
		K_AVAIL} kind_e;

	typedef struct {
		int         test;
		kind_e      kind;
		mfp_reg_e   addr;
		logic [7:0] data;
		logic [7:0] exp;
	} step_t;

	logic clk;
	logic reset;
	logic [7:0] din;
	logic sel;
	logic [4:0] addr;
	logic ds;
	logic rw;
	logic [7:0] dout;
	logic irq;
	logic iack;
	logic serial_avail;
	logic strobe_out;
	logic [7:0] serial_data_out;
	logic strobe_in;
	logic [7:0] serial_data_in;
	logic clk_ext;
	logic [1:0] t;
	logic [7:0] gpio;

	step_t steps[$];
	int seed;
	int errors;
	int checks;
	int test_errors;
	int test_checks;
	int test_count;
	string test_names[1:6] = '{"register access", "gpip read mix", "port interrupt priority",
		"timer a event count", "serial fifos", "timer d delay"};

	mfp u_dut (
		.clk(clk),
		.reset(reset),
		.din_i(din),
		.sel_i(sel),
		.addr_i(addr),
		.ds_i(ds),
		.rw_i(rw),
		.dout_o(dout),
		.irq_o(irq),
		.iack_i(iack),
		.serial_avail_o(serial_avail),
		.serial_strobe_out_i(strobe_out),
		.serial_data_o(serial_data_out),
		.serial_strobe_in_i(strobe_in),
		.serial_data_i(serial_data_in),
		.clk_ext_i(clk_ext),
		.t_i(t),
		.gpio_i(gpio)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// external timer clock with six system clocks per period
	always begin
		repeat (3) @(negedge clk);
		clk_ext = ~clk_ext;
	end

	function automatic void add_step(input int test, input kind_e kind, input mfp_reg_e a,
			input logic [7:0] data, input logic [7:0] exp);
		step_t s;
		s.test = test;
		s.kind = kind;
		s.addr = a;
		s.data = data;
		s.exp = exp;
		steps.push_back(s);
	endfunction

	function automatic void check_value(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		checks++;
		test_checks++;
		if (got !== exp) begin
			$display("ERROR %s: got 0x%02h, expected 0x%02h", name, got, exp);
			errors++;
			test_errors++;
		end
	endfunction

	function automatic void note_failure(input string what);
		checks++;
		test_checks++;
		errors++;
		test_errors++;
		$display("%s", what);
	endfunction

	task automatic cpu_write(input mfp_reg_e a, input logic [7:0] d);
		@(negedge clk);
		sel = 1'b1;
		ds = 1'b0;
		rw = 1'b0;
		addr = a;
		din = d;
		@(negedge clk);
		sel = 1'b0;
		ds = 1'b1;
		rw = 1'b1;
	endtask

	task automatic cpu_read(input mfp_reg_e a, output logic [7:0] d);
		@(negedge clk);
		sel = 1'b1;
		ds = 1'b0;
		rw = 1'b1;
		addr = a;
		#(CLK_PERIOD / 4);
		d = dout;
		@(negedge clk);
		sel = 1'b0;
		ds = 1'b1;
	endtask

	// pins pass two synchronizer stages and the edge register
	task automatic set_pins(input logic [7:0] v);
		@(negedge clk);
		gpio = v;
		repeat (4) @(negedge clk);
	endtask

	task automatic wait_irq(input int limit, output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < limit) begin
			@(negedge clk);
			if (irq === 1'b1)
				seen = 1'b1;
			n++;
		end
	endtask

	task automatic watch_irq_low(input int cycles, output bit quiet);
		quiet = 1'b1;
		repeat (cycles) begin
			@(negedge clk);
			if (irq !== 1'b0)
				quiet = 1'b0;
		end
	endtask

	task automatic wait_avail(input int limit, output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < limit) begin
			@(negedge clk);
			if (serial_avail === 1'b1)
				seen = 1'b1;
			n++;
		end
	endtask

	task automatic acknowledge(output logic [7:0] vec);
		@(negedge clk);
		iack = 1'b1;
		#(CLK_PERIOD / 4);
		vec = dout;
		@(negedge clk);
		iack = 1'b0;
	endtask

	task automatic pulse_event(input int n);
		repeat (n) begin
			@(negedge clk);
			t[0] = 1'b1;
			repeat (2) @(negedge clk);
			t[0] = 1'b0;
			repeat (4) @(negedge clk);
		end
	endtask

	task automatic strobe_in_byte(input logic [7:0] b);
		@(negedge clk);
		serial_data_in = b;
		strobe_in = 1'b1;
		repeat (3) @(negedge clk);
		strobe_in = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic strobe_out_pulse();
		@(negedge clk);
		strobe_out = 1'b1;
		repeat (3) @(negedge clk);
		strobe_out = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic run_step(input step_t s);
		logic [7:0] got;
		bit ok;
		case (s.kind)
			K_WR: cpu_write(s.addr, s.data);
			K_RD: begin
				cpu_read(s.addr, got);
				check_value($sformatf("dout_o at %s", s.addr.name()), got, s.exp);
			end
			K_PIN: set_pins(s.data);
			K_IRQ: begin
				wait_irq(IRQ_TIMEOUT, ok);
				if (!ok)
					note_failure("irq_o did not rise before the timeout");
			end
			K_NOIRQ: begin
				watch_irq_low(10, ok);
				if (!ok)
					note_failure("irq_o rose although it should stay low");
			end
			K_IACK: begin
				acknowledge(got);
				check_value("dout_o vector", got, s.exp);
			end
			K_EVT: pulse_event(s.data);
			K_SIN: strobe_in_byte(s.data);
			K_SOUT: begin
				wait_avail(AVAIL_TIMEOUT, ok);
				if (!ok) begin
					note_failure("serial_avail_o stayed low while a byte was expected");
				end else begin
					check_value("serial_data_o", serial_data_out, s.exp);
					strobe_out_pulse();
				end
			end
			K_AVAIL: check_value("serial_avail_o", {7'h00, serial_avail}, s.exp);
			default: note_failure("unknown step kind in the table");
		endcase
	endtask

	function automatic void build_table();
		logic [7:0] gp_reg [3] = '{8'hA5, 8'h0F, 8'hFF};
		logic [7:0] gp_ddr [3] = '{8'hF0, 8'h3C, 8'h00};
		logic [7:0] gp_pin [3] = '{8'h3C, 8'hC3, 8'h5A};
		logic [7:0] gp_exp [3] = '{8'hAC, 8'hCF, 8'h5A};
		logic [7:0] tx_bytes [16];
		logic [7:0] rx_bytes [4];
		// register write and read back and ipr clear by zeros
		add_step(1, K_WR, REG_AER, 8'h5A, 8'h00);
		add_step(1, K_RD, REG_AER, 8'h00, 8'h5A);
		add_step(1, K_WR, REG_AER, 8'h00, 8'h00);
		add_step(1, K_RD, REG_AER, 8'h00, 8'h00);
		add_step(1, K_WR, REG_DDR, 8'hC3, 8'h00);
		add_step(1, K_RD, REG_DDR, 8'h00, 8'hC3);
		add_step(1, K_WR, REG_IERA, 8'hA5, 8'h00);
		add_step(1, K_RD, REG_IERA, 8'h00, 8'hA5);
		add_step(1, K_WR, REG_IERB, 8'h3C, 8'h00);
		add_step(1, K_RD, REG_IERB, 8'h00, 8'h3C);
		add_step(1, K_WR, REG_IMRA, 8'h0F, 8'h00);
		add_step(1, K_RD, REG_IMRA, 8'h00, 8'h0F);
		add_step(1, K_WR, REG_IMRB, 8'hF0, 8'h00);
		add_step(1, K_RD, REG_IMRB, 8'h00, 8'hF0);
		add_step(1, K_WR, REG_VR, VR_VAL, 8'h00);
		add_step(1, K_RD, REG_VR, 8'h00, VR_VAL);
		add_step(1, K_WR, REG_TADR, 8'h37, 8'h00);
		add_step(1, K_RD, REG_TADR, 8'h00, 8'h37);
		add_step(1, K_WR, REG_TBDR, 8'h81, 8'h00);
		add_step(1, K_RD, REG_TBDR, 8'h00, 8'h81);
		add_step(1, K_WR, REG_TCDR, 8'h9C, 8'h00);
		add_step(1, K_RD, REG_TCDR, 8'h00, 8'h9C);
		add_step(1, K_WR, REG_TDDR, 8'h0E, 8'h00);
		add_step(1, K_RD, REG_TDDR, 8'h00, 8'h0E);
		add_step(1, K_PIN, REG_GPIP, 8'h08, 8'h00);
		add_step(1, K_PIN, REG_GPIP, 8'h00, 8'h00);
		add_step(1, K_RD, REG_IPRB, 8'h00, M_G3[7:0]);
		add_step(1, K_WR, REG_IPRB, 8'h00, 8'h00);
		add_step(1, K_RD, REG_IPRB, 8'h00, 8'h00);
		add_step(1, K_WR, REG_IERA, 8'h00, 8'h00);
		add_step(1, K_WR, REG_IERB, 8'h00, 8'h00);
		add_step(1, K_WR, REG_IMRA, 8'h00, 8'h00);
		add_step(1, K_WR, REG_IMRB, 8'h00, 8'h00);
		// output bits come from the register and input bits from the pins
		for (int i = 0; i < 3; i++) begin
			add_step(2, K_WR, REG_GPIP, gp_reg[i], 8'h00);
			add_step(2, K_WR, REG_DDR, gp_ddr[i], 8'h00);
			add_step(2, K_PIN, REG_GPIP, gp_pin[i], 8'h00);
			add_step(2, K_RD, REG_GPIP, 8'h00, gp_exp[i]);
		end
		add_step(2, K_PIN, REG_GPIP, 8'h00, 8'h00);
		add_step(2, K_WR, REG_DDR, 8'h00, 8'h00);
		// gpip5 in service blocks the lower gpip3
		add_step(3, K_WR, REG_VR, VR_VAL, 8'h00);
		add_step(3, K_WR, REG_IERB, M_G5[7:0] | M_G3[7:0], 8'h00);
		add_step(3, K_WR, REG_IMRB, M_G5[7:0] | M_G3[7:0], 8'h00);
		add_step(3, K_PIN, REG_GPIP, 8'h20, 8'h00);
		add_step(3, K_PIN, REG_GPIP, 8'h00, 8'h00);
		add_step(3, K_IRQ, REG_GPIP, 8'h00, 8'h00);
		add_step(3, K_IACK, REG_GPIP, 8'h00, {VR_VAL[7:4], 4'(`MFP_IRQ_GPIP5)});
		add_step(3, K_RD, REG_ISRB, 8'h00, M_G5[7:0]);
		add_step(3, K_RD, REG_IPRB, 8'h00, 8'h00);
		add_step(3, K_PIN, REG_GPIP, 8'h08, 8'h00);
		add_step(3, K_PIN, REG_GPIP, 8'h00, 8'h00);
		add_step(3, K_NOIRQ, REG_GPIP, 8'h00, 8'h00);
		add_step(3, K_RD, REG_IPRB, 8'h00, M_G3[7:0]);
		add_step(3, K_WR, REG_ISRB, 8'h00, 8'h00);
		add_step(3, K_IRQ, REG_GPIP, 8'h00, 8'h00);
		add_step(3, K_IACK, REG_GPIP, 8'h00, {VR_VAL[7:4], 4'(`MFP_IRQ_GPIP3)});
		add_step(3, K_RD, REG_ISRB, 8'h00, M_G3[7:0]);
		add_step(3, K_WR, REG_ISRB, 8'h00, 8'h00);
		add_step(3, K_RD, REG_ISRB, 8'h00, 8'h00);
		add_step(3, K_WR, REG_IERB, 8'h00, 8'h00);
		add_step(3, K_WR, REG_IMRB, 8'h00, 8'h00);
		// timer a counts five falling edges of t_i[0]
		add_step(4, K_WR, REG_IERA, M_TA[15:8], 8'h00);
		add_step(4, K_WR, REG_IMRA, M_TA[15:8], 8'h00);
		add_step(4, K_WR, REG_TADR, 8'h05, 8'h00);
		add_step(4, K_WR, REG_TACR, 8'h08, 8'h00);
		add_step(4, K_EVT, REG_TADR, 8'd4, 8'h00);
		add_step(4, K_RD, REG_TADR, 8'h00, 8'h01);
		add_step(4, K_NOIRQ, REG_TADR, 8'h00, 8'h00);
		add_step(4, K_EVT, REG_TADR, 8'd1, 8'h00);
		add_step(4, K_IRQ, REG_TADR, 8'h00, 8'h00);
		add_step(4, K_IACK, REG_TADR, 8'h00, {VR_VAL[7:4], 4'(`MFP_IRQ_TIMER_A)});
		add_step(4, K_RD, REG_ISRA, 8'h00, M_TA[15:8]);
		add_step(4, K_WR, REG_ISRA, 8'h00, 8'h00);
		add_step(4, K_WR, REG_TACR, 8'h00, 8'h00);
		add_step(4, K_WR, REG_IERA, 8'h00, 8'h00);
		add_step(4, K_WR, REG_IMRA, 8'h00, 8'h00);
		// transmit fifo holds 15 bytes and the 16th write is dropped
		for (int i = 0; i < 16; i++)
			tx_bytes[i] = 8'($random(seed));
		for (int i = 0; i < 4; i++)
			rx_bytes[i] = 8'($random(seed));
		add_step(5, K_RD, REG_TSR, 8'h00, 8'h80);
		add_step(5, K_RD, REG_RSR, 8'h00, 8'h00);
		for (int i = 0; i < 15; i++)
			add_step(5, K_WR, REG_UDR, tx_bytes[i], 8'h00);
		add_step(5, K_RD, REG_TSR, 8'h00, 8'h00);
		add_step(5, K_WR, REG_UDR, tx_bytes[15], 8'h00);
		for (int i = 0; i < 15; i++)
			add_step(5, K_SOUT, REG_UDR, 8'h00, tx_bytes[i]);
		add_step(5, K_AVAIL, REG_UDR, 8'h00, 8'h00);
		add_step(5, K_RD, REG_TSR, 8'h00, 8'h80);
		for (int i = 0; i < 4; i++)
			add_step(5, K_SIN, REG_UDR, rx_bytes[i], 8'h00);
		add_step(5, K_RD, REG_RSR, 8'h00, 8'h80);
		for (int i = 0; i < 4; i++)
			add_step(5, K_RD, REG_UDR, 8'h00, rx_bytes[i]);
		add_step(5, K_RD, REG_RSR, 8'h00, 8'h00);
		// timer d divides by 4 and counts two steps
		add_step(6, K_WR, REG_IERB, M_TD[7:0], 8'h00);
		add_step(6, K_WR, REG_IMRB, M_TD[7:0], 8'h00);
		add_step(6, K_WR, REG_TDDR, 8'h02, 8'h00);
		add_step(6, K_WR, REG_TCDCR, 8'h01, 8'h00);
		add_step(6, K_IRQ, REG_TDDR, 8'h00, 8'h00);
		add_step(6, K_IACK, REG_TDDR, 8'h00, {VR_VAL[7:4], 4'(`MFP_IRQ_TIMER_D)});
		add_step(6, K_WR, REG_TCDCR, 8'h00, 8'h00);
		add_step(6, K_WR, REG_ISRB, 8'h00, 8'h00);
		add_step(6, K_RD, REG_ISRB, 8'h00, 8'h00);
		add_step(6, K_WR, REG_IERB, 8'h00, 8'h00);
		add_step(6, K_WR, REG_IMRB, 8'h00, 8'h00);
	endfunction

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		din = 8'h00;
		sel = 1'b0;
		addr = 5'h00;
		ds = 1'b1;
		rw = 1'b1;
		iack = 1'b0;
		strobe_out = 1'b0;
		strobe_in = 1'b0;
		serial_data_in = 8'h00;
		clk_ext = 1'b0;
		t = 2'b00;
		gpio = 8'h00;
		errors = 0;
		checks = 0;
		test_errors = 0;
		test_checks = 0;
		test_count = 0;
		seed = 32'hb515f367;
		build_table();
		repeat (8) @(negedge clk);
		reset = 1'b0;
		repeat (2) @(negedge clk);
		for (int i = 0; i < steps.size(); i++) begin
			run_step(steps[i]);
			if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
				$display("test %0d %s: %0d checks, %0d errors", steps[i].test,
					test_names[steps[i].test], test_checks, test_errors);
				test_count++;
				test_checks = 0;
				test_errors = 0;
			end
		end
		if (u_dut.u_mfp_assert.fail_count != 0)
			note_failure("concurrent assertions in the bound checker failed");
		$display("%0d tests, %0d checks, %0d errors", test_count, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+.
mfp_pkg.sv
mfp_timer.sv
mfp_byte_fifo.sv
mfp_irq_ctrl.sv
mfp.sv
mfp_assert.sv
tb_mfp.sv
